// ==== list.f ====
+incdir+tests
design/sp_bus_pkg.sv
design/sp_regs_pkg.sv
design/sp_local_mem.sv
design/sp_byte_bridge.sv
design/sp_ctrl_regs.sv
design/sp_data_bus.sv
tests/sp_data_bus_tb.sv

// ==== tests/sp_tb_vectors.svh ====
task automatic load_vectors();
   // each row gives the operation, address, write data or key, sel and expected data or level
   // a key row carries the key code in bits 6 to 0 and the shift state in bits 10 to 7
   // local memory takes a full word and then single lanes
   add_row(OP_WRITE, 32'h0000_0008, 32'h1234_5678, 4'b1111, 32'h0000_0000);
   add_row(OP_READ,  32'h0000_0008, 32'h0000_0000, 4'b1111, 32'h1234_5678);
   add_row(OP_WRITE, 32'h0000_0008, 32'haabb_ccdd, 4'b0100, 32'h0000_0000);
   add_row(OP_READ,  32'h0000_0008, 32'h0000_0000, 4'b1111, 32'h12bb_5678);
   add_row(OP_WRITE, 32'h0000_0008, 32'h1122_3344, 4'b1001, 32'h0000_0000);
   add_row(OP_READ,  32'h0000_0008, 32'h0000_0000, 4'b1111, 32'h11bb_5644);
   add_row(OP_WRITE, 32'h0000_0ffc, 32'hcafe_f00d, 4'b1111, 32'h0000_0000);
   add_row(OP_READ,  32'h0000_0ffc, 32'h0000_0000, 4'b1111, 32'hcafe_f00d);
   add_row(OP_READ,  32'h0000_0008, 32'h0000_0000, 4'b1111, 32'h11bb_5644);
   // the byte slave starts out filled with the byte address xor 8'ha5
   add_row(OP_READ,  32'h8000_0040, 32'h0000_0000, 4'b1111, 32'he5e4_e7e6);
   add_row(OP_WRITE, 32'h8012_3404, 32'hdead_beef, 4'b1111, 32'h0000_0000);
   add_row(OP_READ,  32'h8012_3404, 32'h0000_0000, 4'b1111, 32'hdead_beef);
   add_row(OP_WRITE, 32'h8000_0010, 32'h1122_3344, 4'b0101, 32'h0000_0000);
   add_row(OP_READ,  32'h8000_0010, 32'h0000_0000, 4'b1111, 32'hb522_b744);
   // control registers
   add_row(OP_WRITE, ADR_LED,       32'h0000_0001, 4'b1111, 32'h0000_0000);
   add_row(OP_READ,  ADR_LED,       32'h0000_0000, 4'b1111, 32'h0000_0001);
   add_row(OP_WRITE, ADR_LED,       32'h0000_0002, 4'b1111, 32'h0000_0000);
   add_row(OP_READ,  ADR_LED,       32'h0000_0000, 4'b1111, 32'h0000_0002);
   add_row(OP_WRITE, ADR_LED,       32'h0000_0003, 4'b1111, 32'h0000_0000);
   add_row(OP_READ,  ADR_LED,       32'h0000_0000, 4'b1111, 32'h0000_0003);
   add_row(OP_WRITE, ADR_SWRST,     32'h0000_0015, 4'b1111, 32'h0000_0000);
   add_row(OP_READ,  ADR_SWRST,     32'h0000_0000, 4'b1111, 32'h0000_0000);
   add_row(OP_WRITE, ADR_SCRATCH,   32'h0102_0304, 4'b1111, 32'h0000_0000);
   add_row(OP_WRITE, ADR_SCRATCH,   32'hffff_ffff, 4'b0010, 32'h0000_0000);
   add_row(OP_READ,  ADR_SCRATCH,   32'h0000_0000, 4'b1111, 32'h0102_ff04);
   add_row(OP_READ,  ADR_ID,        32'h0000_0000, 4'b1111, SP_ID_VALUE);
   // the second key finds the keyboard latch already full
   add_row(OP_KEY,   32'h0000_0000, 32'h0000_02aa, 4'b0000, 32'h0000_0001);
   add_row(OP_KEY,   32'h0000_0000, 32'h0000_0191, 4'b0000, 32'h0000_0001);
   add_row(OP_READ,  ADR_KEYB,      32'h0000_0000, 4'b1111, 32'h8000_02aa);
   add_row(OP_READ,  ADR_KEYB,      32'h0000_0000, 4'b1111, 32'h0000_02aa);
   // the other targets keep their contents after an unmapped write
   add_row(OP_WRITE, 32'h9000_0008, 32'hffff_ffff, 4'b1111, 32'h0000_0000);
   add_row(OP_READ,  32'h9000_0008, 32'h0000_0000, 4'b1111, 32'h0000_0000);
   add_row(OP_READ,  32'h0000_0008, 32'h0000_0000, 4'b1111, 32'h11bb_5644);
   add_row(OP_READ,  ADR_SCRATCH,   32'h0000_0000, 4'b1111, 32'h0102_ff04);
   add_row(OP_READ,  32'h8000_0008, 32'h0000_0000, 4'b1111, 32'hadac_afae);
endtask

// ==== tests/sp_data_bus_tb.sv ====
`timescale 1ns/1ns

module sp_data_bus_tb;
   import sp_bus_pkg::*;
   import sp_regs_pkg::*;

   typedef enum int {OP_WRITE, OP_READ, OP_KEY} op_e;

   localparam int          ACK_TIMEOUT = 64;
   localparam logic [31:0] ADR_LED     = 32'hff00_0000;
   localparam logic [31:0] ADR_SWRST   = 32'hff00_0004;
   localparam logic [31:0] ADR_SCRATCH = 32'hff00_0008;
   localparam logic [31:0] ADR_KEYB    = 32'hff00_000c;
   localparam logic [31:0] ADR_ID      = 32'hff00_0010;

   logic        clk;
   logic        reset_i;
   logic [31:0] cpu_adr_i;
   logic [31:0] cpu_dat_i;
   logic [3:0]  cpu_sel_i;
   logic        cpu_we_i;
   logic        cpu_stb_i;
   logic        cpu_cyc_i;
   logic        cpu_ack_o;
   logic [31:0] cpu_dat_o;
   logic [23:0] wb_adr_o;
   logic [7:0]  wb_dat_o;
   logic [7:0]  wb_dat_i;
   logic        wb_we_o;
   logic        wb_sel_o;
   logic        wb_stb_o;
   logic        wb_cyc_o;
   logic        wb_ack_i;
   logic        led_red_o;
   logic        led_green_o;
   logic [4:0]  sw_reset_o;
   logic        keypress_i;
   logic [6:0]  keycode_i;
   logic [3:0]  shift_state_i;
   logic        keyboard_block_o;

   logic [7:0]  byte_mem [0:255];  // byte-bus slave storage
   logic [23:0] seen_adr [$];      // byte addresses of the current access, in order
   logic [31:0] lfsr_q = 32'h53c4;
   op_e         op_q [$];
   logic [31:0] adr_q [$];
   logic [31:0] dat_q [$];
   logic [3:0]  sel_q [$];
   logic [31:0] exp_q [$];
   int          checks = 0;
   int          errors = 0;
   int          timeouts = 0;

   sp_data_bus UUT (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // taps of x^32 + x^22 + x^2 + x + 1 with the register shifting right
   function automatic logic lfsr_next_bit();
      logic out;
      out = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (out) begin
         lfsr_q = lfsr_q ^ 32'h8020_0003;
      end
      return out;
   endfunction

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic add_row(input op_e op, input logic [31:0] adr, input logic [31:0] dat,
                          input logic [3:0] sel, input logic [31:0] exp);
      op_q.push_back(op);
      adr_q.push_back(adr);
      dat_q.push_back(dat);
      sel_q.push_back(sel);
      exp_q.push_back(exp);
   endtask

   `include "sp_tb_vectors.svh"

   // lane k travels as byte k of the word, lane 0 being the most significant byte
   task automatic inspect_byte_bus(input logic [31:0] adr, input logic [31:0] dat,
                                   input logic [3:0] sel, input logic we);
      compare_value("byte transfers", seen_adr.size(), 4);
      for (int k = 0; k < 4; k++) begin
         if (k < seen_adr.size()) begin
            compare_value("wb_adr_o", seen_adr[k], {adr[23:2], 2'(k)});
         end
         if (we && sel[3-k]) begin
            compare_value("byte_mem", byte_mem[{adr[7:2], 2'(k)}], dat[31-8*k -: 8]);
         end
      end
   endtask

   task automatic apply_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                               input logic [3:0] sel, input logic [31:0] exp);
      logic [31:0] rdata;
      logic [4:0]  sw_at_ack;
      int          n;
      bit          ok;
      n = 0;
      ok = 1'b0;
      seen_adr.delete();
      cpu_adr_i <= adr;
      cpu_dat_i <= dat;
      cpu_sel_i <= sel;
      cpu_we_i  <= we;
      cpu_stb_i <= 1'b1;
      cpu_cyc_i <= 1'b1;
      while (!ok && n < ACK_TIMEOUT) begin
         @(posedge clk);
         n++;
         ok = (cpu_ack_o === 1'b1);
      end
      rdata = cpu_dat_o;
      sw_at_ack = sw_reset_o;
      cpu_stb_i <= 1'b0;
      cpu_cyc_i <= 1'b0;
      @(posedge clk);
      if (!ok) begin
         timeouts++;
         $display("timeout: the access to address %h was never acknowledged", adr);
      end else begin
         compare_value("cpu_ack_o", cpu_ack_o, 1'b0);  // a second ack would show here
         if (adr[31:24] == SP_REGION_BYTE) begin
            inspect_byte_bus(adr, dat, sel, we);
         end else begin
            compare_value("ack latency", n - 1, 1);
         end
         if (!we) begin
            compare_value("cpu_dat_o", rdata, exp);
         end
         if (we && adr == ADR_LED && sel[0]) begin
            compare_value("led_green_o", led_green_o, dat[0]);
            compare_value("led_red_o", led_red_o, dat[1]);
         end
         if (we && adr == ADR_SWRST && sel[0]) begin
            compare_value("sw_reset_o", sw_at_ack, dat[4:0]);
            compare_value("sw_reset_o", sw_reset_o, 5'h00);  // the pulse lasts one cycle
         end
         if (!we && adr == ADR_KEYB) begin
            compare_value("keyboard_block_o", keyboard_block_o, 1'b0);
         end
      end
   endtask

   // the key code sits in bits 6 to 0 and the shift state in bits 10 to 7
   task automatic press_key(input logic [31:0] dat, input logic exp_block);
      keycode_i     <= dat[6:0];
      shift_state_i <= dat[10:7];
      keypress_i    <= 1'b1;
      @(posedge clk);
      keypress_i <= 1'b0;
      @(posedge clk);
      compare_value("keyboard_block_o", keyboard_block_o, exp_block);
   endtask

   initial begin : byte_slave
      int wait_cycles;
      wb_ack_i <= 1'b0;
      wb_dat_i <= 8'h00;
      for (int i = 0; i < 256; i++) begin
         byte_mem[i] = 8'(i) ^ 8'ha5;
      end
      forever begin
         @(posedge clk);
         if (wb_stb_o === 1'b1 && !wb_ack_i) begin
            compare_value("wb_cyc_o", wb_cyc_o, 1'b1);  // every strobe sits inside a cycle
            wait_cycles = 0;
            wait_cycles[1] = lfsr_next_bit();
            wait_cycles[0] = lfsr_next_bit();
            repeat (wait_cycles) @(posedge clk);
            seen_adr.push_back(wb_adr_o);
            if (wb_we_o && wb_sel_o) begin
               byte_mem[wb_adr_o[7:0]] = wb_dat_o;
            end
            wb_dat_i <= byte_mem[wb_adr_o[7:0]];
            wb_ack_i <= 1'b1;
            @(posedge clk);
            wb_ack_i <= 1'b0;
         end
      end
   end

   initial begin : main
      reset_i       <= 1'b1;
      cpu_adr_i     <= 32'h0;
      cpu_dat_i     <= 32'h0;
      cpu_sel_i     <= 4'h0;
      cpu_we_i      <= 1'b0;
      cpu_stb_i     <= 1'b0;
      cpu_cyc_i     <= 1'b0;
      keypress_i    <= 1'b0;
      keycode_i     <= 7'h00;
      shift_state_i <= 4'h0;
      repeat (16) @(posedge clk);
      reset_i <= 1'b0;
      @(posedge clk);
      compare_value("cpu_ack_o", cpu_ack_o, 1'b0);
      compare_value("wb_stb_o", wb_stb_o, 1'b0);
      compare_value("wb_cyc_o", wb_cyc_o, 1'b0);
      compare_value("led_red_o", led_red_o, 1'b0);
      compare_value("led_green_o", led_green_o, 1'b0);
      compare_value("sw_reset_o", sw_reset_o, 5'h00);
      compare_value("keyboard_block_o", keyboard_block_o, 1'b0);
      load_vectors();
      for (int r = 0; r < op_q.size(); r++) begin
         if (op_q[r] == OP_KEY) begin
            press_key(dat_q[r], exp_q[r][0]);
         end else begin
            apply_access(op_q[r] == OP_WRITE, adr_q[r], dat_q[r], sel_q[r], exp_q[r]);
         end
      end
      $display("checks: %0d, mismatches: %0d, timeouts: %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// ==== design/sp_data_bus.sv ====
`timescale 1ns/1ns

module sp_data_bus (
   input  logic                                  clk,
   input  logic                                  reset_i,
   input  logic [0:sp_bus_pkg::SP_ADR_W-1]       cpu_adr_i,
   input  logic [0:sp_bus_pkg::SP_DAT_W-1]       cpu_dat_i,
   input  logic [0:sp_bus_pkg::SP_SEL_W-1]       cpu_sel_i,
   input  logic                                  cpu_we_i,
   input  logic                                  cpu_stb_i,
   input  logic                                  cpu_cyc_i,
   output logic                                  cpu_ack_o,
   output logic [0:sp_bus_pkg::SP_DAT_W-1]       cpu_dat_o,
   output logic [0:sp_bus_pkg::SP_BYTE_ADR_W-1]  wb_adr_o,
   output logic [0:sp_bus_pkg::SP_LANE_W-1]      wb_dat_o,
   input  logic [0:sp_bus_pkg::SP_LANE_W-1]      wb_dat_i,
   output logic                                  wb_we_o,
   output logic                                  wb_sel_o,
   output logic                                  wb_stb_o,
   output logic                                  wb_cyc_o,
   input  logic                                  wb_ack_i,
   output logic                                  led_red_o,
   output logic                                  led_green_o,
   output logic [0:sp_regs_pkg::SP_SW_RESET_W-1] sw_reset_o,
   input  logic                                  keypress_i,
   input  logic [0:sp_regs_pkg::SP_KEYCODE_W-1]  keycode_i,
   input  logic [0:sp_regs_pkg::SP_SHIFT_W-1]    shift_state_i,
   output logic                                  keyboard_block_o
);
   import sp_bus_pkg::*;
   import sp_regs_pkg::*;

   sp_region_e          region;
   logic                bus_stb;
   logic                mem_stb;
   logic                br_stb;
   logic                ctrl_stb;
   logic                unm_stb;
   logic                mem_ack;
   logic                br_ack;
   logic                ctrl_ack;
   logic                unm_ack;
   logic [0:SP_DAT_W-1] mem_dat;
   logic [0:SP_DAT_W-1] br_dat;
   logic [0:SP_DAT_W-1] ctrl_dat;

   always_comb begin
      if (!cpu_adr_i[0]) begin
         region = RG_MEM;  // the whole lower half of the map is local memory
      end else if (cpu_adr_i[0:SP_REGION_W-1] == SP_REGION_BYTE) begin
         region = RG_BYTE;
      end else if (cpu_adr_i[0:SP_REGION_W-1] == SP_REGION_CTRL) begin
         region = RG_CTRL;
      end else begin
         region = RG_NONE;
      end
   end

   assign bus_stb  = cpu_stb_i && cpu_cyc_i;
   assign mem_stb  = bus_stb && (region == RG_MEM);
   assign br_stb   = bus_stb && (region == RG_BYTE);
   assign ctrl_stb = bus_stb && (region == RG_CTRL);
   assign unm_stb  = bus_stb && (region == RG_NONE);

   // unmapped accesses still complete so the master never waits forever
   always_ff @(posedge clk) begin
      if (reset_i) begin
         unm_ack <= 1'b0;
      end else begin
         unm_ack <= unm_stb && !unm_ack;
      end
   end

   assign cpu_ack_o = mem_ack || br_ack || ctrl_ack || unm_ack;

   always_comb begin
      case (region)
         RG_MEM:  cpu_dat_o = mem_dat;
         RG_BYTE: cpu_dat_o = br_dat;
         RG_CTRL: cpu_dat_o = ctrl_dat;
         default: cpu_dat_o = '0;
      endcase
   end

   sp_local_mem u_mem (
      .clk     (clk),
      .reset_i (reset_i),
      .adr_i   (cpu_adr_i[SP_ADR_W-2-SP_MEM_AW:SP_ADR_W-3]),
      .dat_i   (cpu_dat_i),
      .sel_i   (cpu_sel_i),
      .we_i    (cpu_we_i),
      .stb_i   (mem_stb),
      .ack_o   (mem_ack),
      .dat_o   (mem_dat)
   );

   sp_byte_bridge u_bridge (
      .clk      (clk),
      .reset_i  (reset_i),
      .adr_i    (cpu_adr_i[SP_REGION_W:SP_REGION_W+SP_BRIDGE_AW-1]),
      .dat_i    (cpu_dat_i),
      .sel_i    (cpu_sel_i),
      .we_i     (cpu_we_i),
      .stb_i    (br_stb),
      .ack_o    (br_ack),
      .dat_o    (br_dat),
      .wb_adr_o (wb_adr_o),
      .wb_dat_o (wb_dat_o),
      .wb_dat_i (wb_dat_i),
      .wb_we_o  (wb_we_o),
      .wb_sel_o (wb_sel_o),
      .wb_stb_o (wb_stb_o),
      .wb_cyc_o (wb_cyc_o),
      .wb_ack_i (wb_ack_i)
   );

   sp_ctrl_regs u_regs (
      .clk              (clk),
      .reset_i          (reset_i),
      .adr_i            (cpu_adr_i[SP_ADR_W-2-SP_REG_AW:SP_ADR_W-3]),
      .dat_i            (cpu_dat_i),
      .sel_i            (cpu_sel_i),
      .we_i             (cpu_we_i),
      .stb_i            (ctrl_stb),
      .ack_o            (ctrl_ack),
      .dat_o            (ctrl_dat),
      .led_red_o        (led_red_o),
      .led_green_o      (led_green_o),
      .sw_reset_o       (sw_reset_o),
      .keypress_i       (keypress_i),
      .keycode_i        (keycode_i),
      .shift_state_i    (shift_state_i),
      .keyboard_block_o (keyboard_block_o)
   );

endmodule

// ==== design/sp_ctrl_regs.sv ====
`timescale 1ns/1ns

module sp_ctrl_regs (
   input  logic                                  clk,
   input  logic                                  reset_i,
   input  logic [0:sp_regs_pkg::SP_REG_AW-1]     adr_i,
   input  logic [0:sp_bus_pkg::SP_DAT_W-1]       dat_i,
   input  logic [0:sp_bus_pkg::SP_SEL_W-1]       sel_i,
   input  logic                                  we_i,
   input  logic                                  stb_i,
   output logic                                  ack_o,
   output logic [0:sp_bus_pkg::SP_DAT_W-1]       dat_o,
   output logic                                  led_red_o,
   output logic                                  led_green_o,
   output logic [0:sp_regs_pkg::SP_SW_RESET_W-1] sw_reset_o,
   input  logic                                  keypress_i,
   input  logic [0:sp_regs_pkg::SP_KEYCODE_W-1]  keycode_i,
   input  logic [0:sp_regs_pkg::SP_SHIFT_W-1]    shift_state_i,
   output logic                                  keyboard_block_o
);
   import sp_bus_pkg::*;
   import sp_regs_pkg::*;

   sp_reg_e                  reg_sel;
   logic                     access;
   logic                     wr;
   logic                     rd;
   logic                     kb_capture;
   logic                     led_red_q;
   logic                     led_green_q;
   logic [0:SP_SW_RESET_W-1] sw_reset_q;
   logic [0:SP_DAT_W-1]      scratch_q;
   logic                     kb_valid_q;
   logic [0:SP_KEYCODE_W-1]  kb_code_q;
   logic [0:SP_SHIFT_W-1]    kb_shift_q;
   logic [0:SP_DAT_W-1]      rd_data;

   assign reg_sel    = sp_reg_e'(adr_i);
   assign access     = stb_i && !ack_o;
   assign wr         = access && we_i;
   assign rd         = access && !we_i;
   assign kb_capture = keypress_i && !kb_valid_q;  // the first key wins until software reads it

   always_comb begin
      case (reg_sel)
         REG_LED: begin
            rd_data                   = '0;
            rd_data[SP_LED_RED_BIT]   = led_red_q;
            rd_data[SP_LED_GREEN_BIT] = led_green_q;
         end
         REG_SCRATCH: begin
            rd_data = scratch_q;
         end
         REG_KEYBOARD: begin
            rd_data = {kb_valid_q, {SP_KB_PAD_W{1'b0}}, kb_shift_q, kb_code_q};
         end
         REG_ID: begin
            rd_data = SP_ID_VALUE;
         end
         default: begin
            rd_data = '0;  // the reset pulses and the unused offsets read as zero
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_o       <= 1'b0;
         led_red_q   <= 1'b0;
         led_green_q <= 1'b0;
         sw_reset_q  <= '0;
         kb_valid_q  <= 1'b0;
      end else begin
         ack_o      <= access;
         sw_reset_q <= '0;
         // the LED and reset bits all sit in the last byte lane
         if (wr && reg_sel == REG_LED && sel_i[SP_SEL_W-1]) begin
            led_red_q   <= dat_i[SP_LED_RED_BIT];
            led_green_q <= dat_i[SP_LED_GREEN_BIT];
         end
         if (wr && reg_sel == REG_SW_RESET && sel_i[SP_SEL_W-1]) begin
            sw_reset_q <= dat_i[SP_DAT_W-SP_SW_RESET_W:SP_DAT_W-1];
         end
         if (kb_capture) begin
            kb_valid_q <= 1'b1;
         end else if (rd && reg_sel == REG_KEYBOARD) begin
            kb_valid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (kb_capture) begin
         kb_code_q  <= keycode_i;
         kb_shift_q <= shift_state_i;
      end
      if (wr && reg_sel == REG_SCRATCH) begin
         for (int i = 0; i < SP_SEL_W; i++) begin
            if (sel_i[i]) begin
               scratch_q[i*SP_LANE_W +: SP_LANE_W] <= dat_i[i*SP_LANE_W +: SP_LANE_W];
            end
         end
      end
      if (access) begin
         dat_o <= rd_data;
      end
   end

   assign led_red_o        = led_red_q;
   assign led_green_o      = led_green_q;
   assign sw_reset_o       = sw_reset_q;
   assign keyboard_block_o = kb_valid_q;  // the latch holds off the keyboard until it is read

endmodule

// ==== design/sp_byte_bridge.sv ====
`timescale 1ns/1ns

module sp_byte_bridge (
   input  logic                                 clk,
   input  logic                                 reset_i,
   input  logic [0:sp_bus_pkg::SP_BRIDGE_AW-1]  adr_i,
   input  logic [0:sp_bus_pkg::SP_DAT_W-1]      dat_i,
   input  logic [0:sp_bus_pkg::SP_SEL_W-1]      sel_i,
   input  logic                                 we_i,
   input  logic                                 stb_i,
   output logic                                 ack_o,
   output logic [0:sp_bus_pkg::SP_DAT_W-1]      dat_o,
   output logic [0:sp_bus_pkg::SP_BYTE_ADR_W-1] wb_adr_o,
   output logic [0:sp_bus_pkg::SP_LANE_W-1]     wb_dat_o,
   input  logic [0:sp_bus_pkg::SP_LANE_W-1]     wb_dat_i,
   output logic                                 wb_we_o,
   output logic                                 wb_sel_o,
   output logic                                 wb_stb_o,
   output logic                                 wb_cyc_o,
   input  logic                                 wb_ack_i
);
   import sp_bus_pkg::*;

   sp_bridge_state_e         state_q;
   logic [0:SP_LANE_IDX_W-1] lane_q;
   logic [0:SP_DAT_W-1]      shift_q;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state_q <= BR_IDLE;
         lane_q  <= '0;
      end else begin
         case (state_q)
            BR_IDLE: begin
               lane_q <= '0;
               if (stb_i) begin
                  state_q <= BR_XFER;
               end
            end
            BR_XFER: begin
               if (!stb_i) begin
                  state_q <= BR_IDLE;  // the master abandoned the access
               end else if (wb_ack_i) begin
                  lane_q <= lane_q + 1'b1;
                  if (lane_q == SP_LAST_LANE) begin
                     state_q <= BR_DONE;
                  end
               end
            end
            BR_DONE: begin
               state_q <= BR_IDLE;  // the master drops stb while we sit here
            end
            default: begin
               state_q <= BR_IDLE;
            end
         endcase
      end
   end

   // each returned byte enters at the bottom so lane 0 ends up on top
   always_ff @(posedge clk) begin
      if (state_q == BR_XFER && wb_ack_i) begin
         shift_q <= {shift_q[SP_LANE_W:SP_DAT_W-1], wb_dat_i};
      end
   end

   assign ack_o = (state_q == BR_DONE);
   assign dat_o = shift_q;

   assign wb_adr_o = {adr_i, lane_q};
   assign wb_dat_o = dat_i[lane_q*SP_LANE_W +: SP_LANE_W];
   assign wb_sel_o = sel_i[lane_q];
   assign wb_we_o  = we_i;
   assign wb_stb_o = (state_q == BR_XFER) && stb_i;
   assign wb_cyc_o = stb_i && (state_q != BR_DONE);

endmodule

// ==== design/sp_local_mem.sv ====
`timescale 1ns/1ns

module sp_local_mem (
   input  logic                             clk,
   input  logic                             reset_i,
   input  logic [0:sp_bus_pkg::SP_MEM_AW-1] adr_i,
   input  logic [0:sp_bus_pkg::SP_DAT_W-1]  dat_i,
   input  logic [0:sp_bus_pkg::SP_SEL_W-1]  sel_i,
   input  logic                             we_i,
   input  logic                             stb_i,
   output logic                             ack_o,
   output logic [0:sp_bus_pkg::SP_DAT_W-1]  dat_o
);
   import sp_bus_pkg::*;

   logic [0:SP_DAT_W-1] mem [0:SP_MEM_WORDS-1];
   logic                access;

   assign access = stb_i && !ack_o;  // the strobe is still high while ack shows

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= access;
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         if (we_i) begin
            for (int i = 0; i < SP_SEL_W; i++) begin
               if (sel_i[i]) begin
                  mem[adr_i][i*SP_LANE_W +: SP_LANE_W] <= dat_i[i*SP_LANE_W +: SP_LANE_W];
               end
            end
         end
         dat_o <= mem[adr_i];  // read data lines up with ack
      end
   end

endmodule

// ==== design/sp_regs_pkg.sv ====
package sp_regs_pkg;

   // control registers are addressed by word offset inside the 8'hff region
   localparam int SP_REG_AW = 3;

   typedef enum logic [0:SP_REG_AW-1] {
      REG_LED      = 3'd0,
      REG_SW_RESET = 3'd1,
      REG_SCRATCH  = 3'd2,
      REG_KEYBOARD = 3'd3,
      REG_ID       = 3'd4
   } sp_reg_e;

   // field widths
   localparam int SP_SW_RESET_W = 5;
   localparam int SP_KEYCODE_W  = 7;
   localparam int SP_SHIFT_W    = 4;

   // LED bits in REG_LED
   localparam int SP_LED_GREEN_BIT = 31;
   localparam int SP_LED_RED_BIT   = 30;

   // the keyboard word is valid in bit 0, zero padding, shift state, then key code
   localparam int SP_KB_PAD_W = sp_bus_pkg::SP_DAT_W - 1 - SP_SHIFT_W - SP_KEYCODE_W;

   localparam logic [0:31] SP_ID_VALUE = 32'h5350_0001;

endpackage

// ==== design/sp_bus_pkg.sv ====
package sp_bus_pkg;

   // the data bus numbers bits big-endian so bit 0 is the most significant
   localparam int SP_ADR_W      = 32;
   localparam int SP_DAT_W      = 32;
   localparam int SP_SEL_W      = 4;
   localparam int SP_LANE_W     = SP_DAT_W / SP_SEL_W;
   localparam int SP_LANE_IDX_W = $clog2(SP_SEL_W);

   // the last lane of a word is the least significant byte
   localparam logic [0:SP_LANE_IDX_W-1] SP_LAST_LANE = SP_LANE_IDX_W'(SP_SEL_W - 1);

   // the top address byte picks the region when address bit 0 is set
   localparam int                SP_REGION_W    = 8;
   localparam logic [0:SP_REGION_W-1] SP_REGION_BYTE = 8'h80;
   localparam logic [0:SP_REGION_W-1] SP_REGION_CTRL = 8'hff;

   // local word memory
   localparam int SP_MEM_WORDS = 1024;
   localparam int SP_MEM_AW    = 10;

   // the external byte bus carries a word address and a two-bit byte index
   localparam int SP_BYTE_ADR_W = 24;
   localparam int SP_BRIDGE_AW  = SP_BYTE_ADR_W - SP_LANE_IDX_W;

   // regions that the top level decodes from the CPU address
   typedef enum logic [1:0] {
      RG_MEM,
      RG_BYTE,
      RG_CTRL,
      RG_NONE
   } sp_region_e;

   // byte bridge sequencer
   typedef enum logic [1:0] {
      BR_IDLE,
      BR_XFER,
      BR_DONE
   } sp_bridge_state_e;

endpackage
